//--- verif/program_trace.txt
# Hex words separated by spaces, each group opened by a tag line
# Words under program load from word address 0 up, words under expect are GPIO bytes in order
program
# ALU results on addiu operands, stored to GPIO
2401000c 2402fffd 2403000a 00000000 00000000 00232021 00232823 00233024
ac047ffc ac057ffc ac067ffc 00233825 0041402a 00224821 ac077ffc ac087ffc
ac097ffc 0022502a 00615823 00000000 ac0a7ffc ac0b7ffc
# Data RAM store and load, then the loaded word to GPIO
240c00a5 00000000 00000000 ac0c0040 8c0d0040 00000000 00000000 ac0d7ffc
# Not-taken beq, then a taken beq that skips two stores
10230008 240e0033 00000000 00000000 ac0e7ffc 10210005 ac047ffc ac057ffc
ac067ffc ac077ffc ac087ffc ac097ffc
# Countdown loop on bne, then a branch to itself
24100005 00000000 00000000 ac107ffc 2610ffff 00000000 00000000 1600fffb
00000000 00000000 00000000 1000ffff 00000000 00000000 00000000
expect
16 02 08 0e 01 09 00 fe
a5
33 16 02 08 09
05 04 03 02 01

//--- tb.f
+incdir+source
source/mips_pkg.sv
source/instr_fetch.sv
source/instr_decode.sv
source/register_file.sv
source/execute_stage.sv
source/memory_stage.sv
source/mips_pipeline.sv
verif/mips_pipeline_tb.sv

//--- Bender.yml
package:
  name: mips_pipeline

sources:
  - include_dirs:
      - source
    files:
      - source/mips_pkg.sv
      - source/instr_fetch.sv
      - source/instr_decode.sv
      - source/register_file.sv
      - source/execute_stage.sv
      - source/memory_stage.sv
      - source/mips_pipeline.sv
  - target: test
    files:
      - verif/mips_pipeline_tb.sv

//--- verif/mips_pipeline_tb.sv
`default_nettype none

module mips_pipeline_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    localparam string TRACE_FILE   = "verif/program_trace.txt";
    localparam int    GPIO_TIMEOUT = 2000;     // Cycles allowed per expected GPIO value
    localparam int    RESET_CYCLES = 5;

    logic  clk;
    logic  reset;
    word_t paddr;
    word_t pwdata;
    logic  psel;
    logic  penable;
    logic  pwrite;
    gpio_t gpio_data_out;

    word_t program_words [$];
    gpio_t expected_gpio [$];
    int    checks;
    int    errors;
    int    tests_run;
    int    tests_failed;
    bit    aborted;         // Set on a timeout or a bad trace, skips the remaining tests

    mips_pipeline mips_pipeline_i (
        .clk, .reset, .paddr, .pwdata, .psel, .penable, .pwrite, .gpio_data_out
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Tag lines switch between program words and expected GPIO bytes
    task automatic read_trace(output bit ok);
        int               fd;
        int               status;
        int               mode;     // 0 before any tag, 1 program, 2 expect
        logic [8*16-1:0]  token;
        logic [8*128-1:0] rest;
        word_t            value;
        ok = 1'b0;
        mode = 0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the trace file %s", TRACE_FILE);
        end else begin
            ok = 1'b1;
            while ($fscanf(fd, "%s", token) == 1) begin
                if (token == "#") begin
                    status = $fgets(rest, fd);     // Rest of a comment line
                end else if (token == "program") begin
                    mode = 1;
                end else if (token == "expect") begin
                    mode = 2;
                end else begin
                    status = $sscanf(token, "%h", value);
                    if (status != 1 || mode == 0) begin
                        $display("Trace file holds a word that could not be read");
                        ok = 1'b0;
                    end else if (mode == 1) begin
                        program_words.push_back(value);
                    end else begin
                        expected_gpio.push_back(gpio_t'(value));
                    end
                end
            end
            $fclose(fd);
            if (program_words.size() == 0 || expected_gpio.size() == 0) begin
                $display("Trace file has no program words or no expected values");
                ok = 1'b0;
            end
        end
    endtask

    // Setup phase, then access phase, zero wait states
    task automatic apb_write(input word_t addr, input word_t data);
        @(posedge clk);
        paddr   <= addr;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        @(posedge clk);
        penable <= 1'b1;
    endtask

    task automatic load_program();
        foreach (program_words[n]) begin
            apb_write(word_t'(n * 4), program_words[n]);
        end
        @(posedge clk);
        psel    <= 1'b0;        // Bus idle before reset drops
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic pulse_reset(input int cycles);
        @(posedge clk);
        reset <= 1'b1;
        repeat (cycles) @(posedge clk);
        reset <= 1'b0;
    endtask

    // Outputs sampled on the falling edge, away from the DUT's updates
    task automatic wait_gpio_change(input gpio_t last, output gpio_t seen, output bit timed_out);
        int cycles;
        cycles = 0;
        timed_out = 1'b1;
        seen = last;
        while (timed_out && cycles < GPIO_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (gpio_data_out !== last) begin
                seen = gpio_data_out;
                timed_out = 1'b0;
            end
        end
    endtask

    task automatic check_gpio(input gpio_t actual, input gpio_t expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, gpio_data_out 0x%02h, expected 0x%02h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %0d %s passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s failed with %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    // Waits for the next GPIO change and compares it against one expected byte
    task automatic expect_next_gpio(inout gpio_t last, input int n);
        gpio_t seen;
        bit    timed_out;
        wait_gpio_change(last, seen, timed_out);
        if (timed_out) begin
            errors++;
            aborted = 1'b1;
            $display("Timeout, expected GPIO value %0d (0x%02h) never appeared",
                     n + 1, expected_gpio[n]);
        end else begin
            check_gpio(seen, expected_gpio[n], $sformatf("GPIO store %0d", n + 1));
            last = seen;
        end
    endtask

    initial begin
        bit    trace_ok;
        int    errors_before;
        gpio_t last;
        checks = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        aborted = 1'b0;
        reset   <= 1'b1;        // Core held in reset while the program loads
        paddr   <= '0;
        pwdata  <= '0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        read_trace(trace_ok);
        if (!trace_ok) begin
            errors++;
            aborted = 1'b1;
        end else begin
            load_program();
            pulse_reset(RESET_CYCLES);
            @(negedge clk);
            errors_before = errors;
            check_gpio(gpio_data_out, '0, "GPIO after first reset");
            report_test("reset clears GPIO", errors_before);
            errors_before = errors;
            last = '0;
            for (int n = 0; n < expected_gpio.size() && !aborted; n++) begin
                expect_next_gpio(last, n);
            end
            report_test("program GPIO sequence", errors_before);
        end
        if (!aborted) begin
            pulse_reset(RESET_CYCLES);  // Program memory is kept
            @(negedge clk);
            errors_before = errors;
            check_gpio(gpio_data_out, '0, "GPIO after second reset");
            report_test("second reset clears GPIO", errors_before);
            errors_before = errors;
            last = '0;
            expect_next_gpio(last, 0);
            report_test("rerun first store", errors_before);
        end
        $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/mips_pipeline.sv
`default_nettype none

module mips_pipeline (
    input  logic            clk,
    input  logic            reset,
    // APB write port for instruction memory
    input  mips_pkg::word_t paddr,
    input  mips_pkg::word_t pwdata,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    output mips_pkg::gpio_t gpio_data_out
);
    import mips_pkg::*;

    // Fetch to decode
    instr_t   instr_d;
    word_t    pc_plus4_d;

    // Decode and register file
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_data;
    word_t    rt_data;

    // Decode to execute
    word_t    rs_data_e, rt_data_e, imm_ext_e, pc_plus4_e;
    reg_idx_t dest_e;
    alu_op_t  alu_op_e;
    logic     alu_src_imm_e, reg_write_e, mem_write_e, mem_read_e, is_beq_e, is_bne_e;

    // Execute to memory
    word_t    alu_result_m, rt_data_m, branch_target_m;
    reg_idx_t dest_m;
    logic     zero_m, reg_write_m, mem_write_m, mem_read_m, is_beq_m, is_bne_m;

    // Memory back to fetch and writeback into the register file
    logic     branch_taken;
    word_t    branch_target;
    logic     wb_en;
    reg_idx_t wb_dest;
    word_t    wb_data;

    instr_fetch instr_fetch_i (
        .clk, .reset, .paddr, .pwdata, .psel, .penable, .pwrite,
        .branch_taken, .branch_target, .instr_d, .pc_plus4_d
    );

    instr_decode instr_decode_i (
        .clk, .reset, .instr_d, .pc_plus4_d, .rs_data, .rt_data, .rs_idx, .rt_idx,
        .rs_data_e, .rt_data_e, .imm_ext_e, .dest_e, .alu_op_e, .alu_src_imm_e,
        .reg_write_e, .mem_write_e, .mem_read_e, .is_beq_e, .is_bne_e, .pc_plus4_e
    );

    register_file register_file_i (
        .clk, .reset, .rs_idx, .rt_idx, .wb_en, .wb_dest, .wb_data, .rs_data, .rt_data
    );

    execute_stage execute_stage_i (
        .clk, .reset, .rs_data_e, .rt_data_e, .imm_ext_e, .dest_e, .alu_op_e,
        .alu_src_imm_e, .reg_write_e, .mem_write_e, .mem_read_e, .is_beq_e, .is_bne_e,
        .pc_plus4_e, .alu_result_m, .zero_m, .rt_data_m, .branch_target_m, .dest_m,
        .reg_write_m, .mem_write_m, .mem_read_m, .is_beq_m, .is_bne_m
    );

    memory_stage memory_stage_i (
        .clk, .reset, .alu_result_m, .zero_m, .rt_data_m, .branch_target_m, .dest_m,
        .reg_write_m, .mem_write_m, .mem_read_m, .is_beq_m, .is_bne_m,
        .branch_taken, .branch_target, .wb_en, .wb_dest, .wb_data, .gpio_data_out
    );

endmodule

`default_nettype wire

//--- source/memory_stage.sv
`default_nettype none

`include "mips_config.svh"

module memory_stage (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::word_t     alu_result_m,       // Memory address or register result
    input  logic                zero_m,
    input  mips_pkg::word_t     rt_data_m,
    input  mips_pkg::word_t     branch_target_m,
    input  mips_pkg::reg_idx_t  dest_m,
    input  logic                reg_write_m,
    input  logic                mem_write_m,
    input  logic                mem_read_m,
    input  logic                is_beq_m,
    input  logic                is_bne_m,
    output logic                branch_taken,
    output mips_pkg::word_t     branch_target,
    output logic                wb_en,
    output mips_pkg::reg_idx_t  wb_dest,
    output mips_pkg::word_t     wb_data,
    output mips_pkg::gpio_t     gpio_data_out
);
    import mips_pkg::*;

    localparam int DMEM_WORDS = 2 ** `DMEM_DEPTH_LOG2;

    logic    gpio_sel;
    word_t   load_data;
    wb_sel_t wb_sel;
    word_t   dmem [DMEM_WORDS];

    // No flush, so the three younger instructions already fetched still run
    assign branch_taken  = (is_beq_m && zero_m) || (is_bne_m && !zero_m);
    assign branch_target = branch_target_m;

    assign gpio_sel  = (alu_result_m == `GPIO_ADDR);
    assign load_data = dmem[alu_result_m[`DMEM_DEPTH_LOG2+1:2]];
    assign wb_sel    = mem_read_m ? WB_MEM : WB_ALU;

    always_ff @(posedge clk) begin
        if (mem_write_m && !gpio_sel) begin
            dmem[alu_result_m[`DMEM_DEPTH_LOG2+1:2]] <= rt_data_m;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            gpio_data_out <= '0;
            wb_en         <= 1'b0;
        end else begin
            if (mem_write_m && gpio_sel) begin
                gpio_data_out <= rt_data_m[`GPIO_WIDTH-1:0];   // Low byte only
            end
            wb_en <= reg_write_m;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest <= dest_m;
        wb_data <= (wb_sel == WB_MEM) ? load_data : alu_result_m;
    end

    // Never load and store at once; a load hits data RAM, a store data RAM or GPIO
    mem_access_a: assert property (@(posedge clk) disable iff (reset)
        !(mem_read_m && mem_write_m) &&
        (!(mem_read_m || mem_write_m) || (mem_write_m && gpio_sel) ||
         alu_result_m[`DATA_WIDTH-1:`DMEM_DEPTH_LOG2+2] == '0));

endmodule

`default_nettype wire

//--- source/execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::word_t     rs_data_e,
    input  mips_pkg::word_t     rt_data_e,
    input  mips_pkg::word_t     imm_ext_e,
    input  mips_pkg::reg_idx_t  dest_e,
    input  mips_pkg::alu_op_t   alu_op_e,
    input  logic                alu_src_imm_e,
    input  logic                reg_write_e,
    input  logic                mem_write_e,
    input  logic                mem_read_e,
    input  logic                is_beq_e,
    input  logic                is_bne_e,
    input  mips_pkg::word_t     pc_plus4_e,
    output mips_pkg::word_t     alu_result_m,
    output logic                zero_m,
    output mips_pkg::word_t     rt_data_m,          // Store data
    output mips_pkg::word_t     branch_target_m,
    output mips_pkg::reg_idx_t  dest_m,
    output logic                reg_write_m,
    output logic                mem_write_m,
    output logic                mem_read_m,
    output logic                is_beq_m,
    output logic                is_bne_m
);
    import mips_pkg::*;

    word_t src_b;
    word_t alu_result;
    word_t branch_target;
    logic  zero;

    assign src_b = alu_src_imm_e ? imm_ext_e : rt_data_e;

    always_comb begin
        case (alu_op_e)
            ALU_ADD: alu_result = rs_data_e + src_b;
            ALU_SUB: alu_result = rs_data_e - src_b;
            ALU_AND: alu_result = rs_data_e & src_b;
            ALU_OR:  alu_result = rs_data_e | src_b;
            ALU_SLT: alu_result = word_t'($signed(rs_data_e) < $signed(src_b));  // Signed compare
            default: alu_result = '0;
        endcase
    end

    assign zero          = (alu_result == '0);
    assign branch_target = pc_plus4_e + (imm_ext_e << 2);  // Word offset from PC+4

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_write_m <= 1'b0;
            mem_write_m <= 1'b0;
            mem_read_m  <= 1'b0;
            is_beq_m    <= 1'b0;
            is_bne_m    <= 1'b0;
        end else begin
            reg_write_m <= reg_write_e;
            mem_write_m <= mem_write_e;
            mem_read_m  <= mem_read_e;
            is_beq_m    <= is_beq_e;
            is_bne_m    <= is_bne_e;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_m    <= alu_result;
        zero_m          <= zero;
        rt_data_m       <= rt_data_e;
        branch_target_m <= branch_target;
        dest_m          <= dest_e;
    end

endmodule

`default_nettype wire

//--- source/register_file.sv
`default_nettype none

`include "mips_config.svh"

module register_file (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::reg_idx_t  rs_idx,
    input  mips_pkg::reg_idx_t  rt_idx,
    input  logic                wb_en,
    input  mips_pkg::reg_idx_t  wb_dest,
    input  mips_pkg::word_t     wb_data,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data
);
    import mips_pkg::*;

    localparam int NUM_REGS = 2 ** `REG_ADDR_WIDTH;

    word_t regs [NUM_REGS];

    // Same-cycle writeback is passed straight through to the reader
    assign rs_data = (rs_idx == '0)               ? '0 :        // $zero
                     (wb_en && wb_dest == rs_idx) ? wb_data :
                                                    regs[rs_idx];
    assign rt_data = (rt_idx == '0)               ? '0 :
                     (wb_en && wb_dest == rt_idx) ? wb_data :
                                                    regs[rt_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_dest != '0) begin    // $zero is never written
            regs[wb_dest] <= wb_data;
        end
    end

endmodule

`default_nettype wire

//--- source/instr_decode.sv
`default_nettype none

`include "mips_config.svh"

module instr_decode (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::instr_t    instr_d,
    input  mips_pkg::word_t     pc_plus4_d,
    input  mips_pkg::word_t     rs_data,        // Register file answers combinationally
    input  mips_pkg::word_t     rt_data,
    output mips_pkg::reg_idx_t  rs_idx,
    output mips_pkg::reg_idx_t  rt_idx,
    output mips_pkg::word_t     rs_data_e,
    output mips_pkg::word_t     rt_data_e,
    output mips_pkg::word_t     imm_ext_e,
    output mips_pkg::reg_idx_t  dest_e,
    output mips_pkg::alu_op_t   alu_op_e,
    output logic                alu_src_imm_e,
    output logic                reg_write_e,
    output logic                mem_write_e,
    output logic                mem_read_e,
    output logic                is_beq_e,
    output logic                is_bne_e,
    output mips_pkg::word_t     pc_plus4_e
);
    import mips_pkg::*;

    alu_op_t  alu_op;
    logic     alu_src_imm, reg_write, mem_write, mem_read, is_beq, is_bne;
    logic     use_rd;       // R-type writes rd, I-type writes rt
    word_t    imm_ext;
    reg_idx_t dest;

    assign rs_idx  = instr_d.r.rs;
    assign rt_idx  = instr_d.r.rt;
    assign imm_ext = {{(`DATA_WIDTH-16){instr_d.i.imm16[15]}}, instr_d.i.imm16};
    assign dest    = use_rd ? instr_d.r.rd : instr_d.i.rt;

    always_comb begin
        alu_op      = ALU_ADD;      // Defaults give a bubble
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        mem_write   = 1'b0;
        mem_read    = 1'b0;
        is_beq      = 1'b0;
        is_bne      = 1'b0;
        use_rd      = 1'b0;
        case (instr_d.r.opcode)
            `OP_RTYPE: begin
                use_rd    = 1'b1;
                reg_write = 1'b1;
                case (instr_d.r.funct)
                    `FUNCT_ADDU: alu_op = ALU_ADD;
                    `FUNCT_SUBU: alu_op = ALU_SUB;
                    `FUNCT_AND:  alu_op = ALU_AND;
                    `FUNCT_OR:   alu_op = ALU_OR;
                    `FUNCT_SLT:  alu_op = ALU_SLT;
                    default:     reg_write = 1'b0;     // Also sll $0 nop
                endcase
            end
            `OP_ADDIU: begin
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
            end
            `OP_LW: begin
                alu_src_imm = 1'b1;     // Address = rs + offset
                reg_write   = 1'b1;
                mem_read    = 1'b1;
            end
            `OP_SW: begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
            end
            `OP_BEQ: begin
                alu_op = ALU_SUB;       // Zero flag gives rs == rt
                is_beq = 1'b1;
            end
            `OP_BNE: begin
                alu_op = ALU_SUB;
                is_bne = 1'b1;
            end
            default: ;                  // Unknown opcode stays a bubble
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_write_e <= 1'b0;
            mem_write_e <= 1'b0;
            mem_read_e  <= 1'b0;
            is_beq_e    <= 1'b0;
            is_bne_e    <= 1'b0;
        end else begin
            reg_write_e <= reg_write;
            mem_write_e <= mem_write;
            mem_read_e  <= mem_read;
            is_beq_e    <= is_beq;
            is_bne_e    <= is_bne;
        end
    end

    // Operands and datapath selects
    always_ff @(posedge clk) begin
        rs_data_e     <= rs_data;
        rt_data_e     <= rt_data;
        imm_ext_e     <= imm_ext;
        dest_e        <= dest;
        alu_op_e      <= alu_op;
        alu_src_imm_e <= alu_src_imm;
        pc_plus4_e    <= pc_plus4_d;
    end

endmodule

`default_nettype wire

//--- source/instr_fetch.sv
`default_nettype none

`include "mips_config.svh"

module instr_fetch (
    input  logic              clk,
    input  logic              reset,
    input  mips_pkg::word_t   paddr,
    input  mips_pkg::word_t   pwdata,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic              branch_taken,     // Resolved in the memory stage
    input  mips_pkg::word_t   branch_target,
    output mips_pkg::instr_t  instr_d,
    output mips_pkg::word_t   pc_plus4_d
);
    import mips_pkg::*;

    localparam int    IMEM_WORDS = 2 ** `IMEM_DEPTH_LOG2;
    localparam word_t IMEM_BASE  = `RESET_PC;

    word_t  pc;
    word_t  pc_plus4;
    word_t  pc_next;
    instr_t instr_f;
    logic   apb_write;
    instr_t imem [IMEM_WORDS];

    // Zero-wait-state write lands in the access phase
    assign apb_write = psel && penable && pwrite;

    always_ff @(posedge clk) begin
        if (apb_write) begin
            imem[paddr[`IMEM_DEPTH_LOG2+1:2]] <= instr_t'(pwdata);   // Word index
        end
    end

    assign instr_f  = imem[pc[`IMEM_DEPTH_LOG2+1:2]];   // Asynchronous read
    assign pc_plus4 = pc + `DATA_WIDTH'(4);
    assign pc_next  = branch_taken ? branch_target : pc_plus4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= `RESET_PC;
            instr_d <= '0;                  // All-zero word decodes as a bubble
        end else begin
            pc      <= pc_next;
            instr_d <= instr_f;
        end
    end

    always_ff @(posedge clk) begin
        pc_plus4_d <= pc_plus4;
    end

    // Fetch stays word-aligned and inside the instruction memory window
    pc_in_imem_a: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00 &&
        pc[`DATA_WIDTH-1:`IMEM_DEPTH_LOG2+2] == IMEM_BASE[`DATA_WIDTH-1:`IMEM_DEPTH_LOG2+2]);

    // Program load is only legal while the core is held in reset
    apb_in_reset_a: assert property (@(posedge clk) apb_write |-> reset);

endmodule

`default_nettype wire

//--- source/mips_pkg.sv
`default_nettype none

`include "mips_config.svh"

package mips_pkg;

    typedef logic [`DATA_WIDTH-1:0]     word_t;     // Data or byte address
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_idx_t;  // $0..$31
    typedef logic [`GPIO_WIDTH-1:0]     gpio_t;

    // ALU operations of the kept instruction subset
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,    // Also the compare for beq/bne
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic {
        WB_ALU,     // Register result from the ALU
        WB_MEM      // Register result from data RAM (lw)
    } wb_sel_t;

    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;      // Not decoded, no shifts in this core
        logic [5:0] funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm16;
    } instr_i_t;

    // One fetched word, viewed as R-type or I-type
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

endpackage

`default_nettype wire

//--- source/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Datapath sizes
`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5
`define IMEM_DEPTH_LOG2 8           // 256 instruction words
`define DMEM_DEPTH_LOG2 8           // 256 data words
`define GPIO_WIDTH      8

`define RESET_PC  32'h0040_0000     // First fetch address out of reset
`define GPIO_ADDR 32'h0000_7ffc     // Reachable as a 16-bit offset from $zero

// Primary opcodes
`define OP_RTYPE 6'h00
`define OP_ADDIU 6'h09
`define OP_LW    6'h23
`define OP_SW    6'h2b
`define OP_BEQ   6'h04
`define OP_BNE   6'h05

// R-type function codes
`define FUNCT_ADDU 6'h21
`define FUNCT_SUBU 6'h23
`define FUNCT_AND  6'h24
`define FUNCT_OR   6'h25
`define FUNCT_SLT  6'h2a

`endif
